//--- hw/dcache_pkg.sv
// data cache shared definitions
package dcache_pkg;

    localparam int way_num     = 2;
    localparam int set_num     = 16;
    localparam int line_words  = 4;
    localparam int offset_bits = 4;   // byte offset within a line
    localparam int index_bits  = 4;
    localparam int tag_bits    = 24;

    typedef logic [31:0]               addr_t;
    typedef logic [31:0]               word_t;
    typedef logic [3:0]                strb_t;
    typedef logic [32*line_words-1:0]  line_t;   // word 0 in the low bits
    typedef logic [tag_bits-1:0]       tag_t;
    typedef logic [index_bits-1:0]     index_t;

    // one tag array entry
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        lk_word   = 3'd0,
        lk_half   = 3'd1,
        lk_half_u = 3'd2,
        lk_byte   = 3'd3,
        lk_byte_u = 3'd4
    } load_kind_t;

    // cpu side request
    typedef struct packed {
        logic       write;
        addr_t      addr;
        strb_t      strb;
        word_t      wdata;
        load_kind_t load_kind;
    } cpu_req_t;

    // line-wide memory request
    typedef struct packed {
        logic  write;
        addr_t addr;   // line aligned
        line_t data;   // writes only
    } mem_req_t;

endpackage

//--- hw/cache_array.sv
// per-way set storage
module cache_array #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                clk,
    input  logic                rst_n,
    input  dcache_pkg::index_t  index,
    input  logic                we,
    input  entry_t              wdata,
    output entry_t              rdata
);

    entry_t mem [dcache_pkg::set_num];

    // cleared on reset so all tags come up invalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dcache_pkg::set_num; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];   // async read

endmodule

//--- hw/byte_lane_unit.sv
// store merge and load extraction
module byte_lane_unit (
    input  dcache_pkg::word_t      word_in,
    input  dcache_pkg::word_t      wdata,
    input  dcache_pkg::strb_t      wstrb,
    input  logic [1:0]             byte_off,
    input  dcache_pkg::load_kind_t load_kind,
    output dcache_pkg::word_t      merged,
    output dcache_pkg::word_t      load_data
);

    logic [15:0] half_sel;
    logic [7:0]  byte_sel;

    // per-byte strobe mux
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : word_in[8*b +: 8];
        end
    end

    assign half_sel = byte_off[1] ? word_in[31:16] : word_in[15:0];
    assign byte_sel = word_in[8*byte_off +: 8];

    always_comb begin
        case (load_kind)
            dcache_pkg::lk_half: begin
                load_data = {{16{half_sel[15]}}, half_sel};
            end
            dcache_pkg::lk_half_u: begin
                load_data = {16'h0000, half_sel};
            end
            dcache_pkg::lk_byte: begin
                load_data = {{24{byte_sel[7]}}, byte_sel};
            end
            dcache_pkg::lk_byte_u: begin
                load_data = {24'h000000, byte_sel};
            end
            default: begin
                load_data = word_in;   // word load, no extension
            end
        endcase
    end

endmodule

//--- hw/dcache_ctrl.sv
// data cache controller
module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  dcache_pkg::cpu_req_t   req,
    output logic                   req_ready,
    output logic                   resp_valid,
    output dcache_pkg::word_t      resp_rdata,
    output logic                   mem_req_valid,
    output dcache_pkg::mem_req_t   mem_req,
    input  logic                   mem_req_ready,
    input  logic                   mem_resp_valid,
    input  dcache_pkg::line_t      mem_resp_data,
    output dcache_pkg::index_t     index,
    input  dcache_pkg::tag_entry_t tag_rdata [dcache_pkg::way_num],
    input  dcache_pkg::line_t      data_rdata [dcache_pkg::way_num],
    output logic [dcache_pkg::way_num-1:0] tag_we,
    output logic [dcache_pkg::way_num-1:0] data_we,
    output dcache_pkg::tag_entry_t tag_wdata,
    output dcache_pkg::line_t      data_wdata,
    output dcache_pkg::word_t      sel_word,
    output dcache_pkg::word_t      req_wdata,
    output dcache_pkg::strb_t      req_wstrb,
    output logic [1:0]             byte_off,
    output dcache_pkg::load_kind_t load_kind,
    input  dcache_pkg::word_t      merged,
    input  dcache_pkg::word_t      load_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wb_req,
        st_wb_wait,
        st_rf_req,
        st_rf_wait
    } state_t;

    state_t               state, state_next;
    dcache_pkg::cpu_req_t req_q;
    dcache_pkg::tag_t     req_tag;
    logic [1:0]           word_off;
    logic [dcache_pkg::way_num-1:0] hit;
    logic                 hit_any;
    logic                 hit_way;
    logic                 victim;
    logic                 lru [dcache_pkg::set_num];   // points at the next victim
    dcache_pkg::line_t    store_line;

    assign req_tag  = req_q.addr[31 -: dcache_pkg::tag_bits];
    assign index    = req_q.addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
    assign word_off = req_q.addr[dcache_pkg::offset_bits-1:2];
    assign byte_off = req_q.addr[1:0];

    // tag compare across ways
    always_comb begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            hit[w] = tag_rdata[w].valid && (tag_rdata[w].tag == req_tag);
        end
    end

    assign hit_any = |hit;
    assign hit_way = hit[1];        // two ways
    assign victim  = lru[index];

    // byte lane operands
    assign sel_word  = data_rdata[hit_way][32*word_off +: 32];
    assign req_wdata = req_q.wdata;
    assign req_wstrb = req_q.strb;
    assign load_kind = req_q.load_kind;

    always_comb begin
        store_line = data_rdata[hit_way];
        store_line[32*word_off +: 32] = merged;
    end

    assign req_ready     = (state == st_idle);
    assign resp_valid    = (state == st_lookup) && hit_any;
    assign resp_rdata    = load_data;
    assign mem_req_valid = (state == st_wb_req) || (state == st_rf_req);

    always_comb begin
        mem_req.write = (state == st_wb_req);
        mem_req.data  = data_rdata[victim];
        if (state == st_wb_req) begin
            mem_req.addr = {tag_rdata[victim].tag, index, {dcache_pkg::offset_bits{1'b0}}};
        end else begin
            mem_req.addr = {req_tag, index, {dcache_pkg::offset_bits{1'b0}}};
        end
    end

    // array writes, store hit or refill
    always_comb begin
        tag_we           = '0;
        data_we          = '0;
        tag_wdata.valid  = 1'b1;
        tag_wdata.dirty  = 1'b1;
        tag_wdata.tag    = req_tag;
        data_wdata       = store_line;
        if (state == st_lookup && hit_any && req_q.write) begin
            tag_we[hit_way]  = 1'b1;
            data_we[hit_way] = 1'b1;
        end else if (state == st_rf_wait && mem_resp_valid) begin
            tag_we[victim]   = 1'b1;
            data_we[victim]  = 1'b1;
            tag_wdata.dirty  = 1'b0;   // fresh line is clean
            data_wdata       = mem_resp_data;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                if (hit_any) begin
                    state_next = st_idle;
                end else if (tag_rdata[victim].valid && tag_rdata[victim].dirty) begin
                    state_next = st_wb_req;
                end else begin
                    state_next = st_rf_req;
                end
            end
            st_wb_req:  if (mem_req_ready)  state_next = st_wb_wait;
            st_wb_wait: if (mem_resp_valid) state_next = st_rf_req;
            st_rf_req:  if (mem_req_ready)  state_next = st_rf_wait;
            st_rf_wait: if (mem_resp_valid) state_next = st_lookup;   // retry hits
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

    // lru flips to the other way on every hit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dcache_pkg::set_num; i++) begin
                lru[i] <= 1'b0;
            end
        end else if (state == st_lookup && hit_any) begin
            lru[index] <= ~hit_way;
        end
    end

endmodule

//--- hw/dcache_top.sv
// blocking write-back data cache
module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 req_ready,
    output logic                 resp_valid,
    output dcache_pkg::word_t    resp_rdata,
    output logic                 mem_req_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_resp_valid,
    input  dcache_pkg::line_t    mem_resp_data
);

    dcache_pkg::index_t     index;
    dcache_pkg::tag_entry_t tag_rdata [dcache_pkg::way_num];
    dcache_pkg::line_t      data_rdata [dcache_pkg::way_num];
    logic [dcache_pkg::way_num-1:0] tag_we;
    logic [dcache_pkg::way_num-1:0] data_we;
    dcache_pkg::tag_entry_t tag_wdata;
    dcache_pkg::line_t      data_wdata;
    dcache_pkg::word_t      sel_word;
    dcache_pkg::word_t      req_wdata;
    dcache_pkg::strb_t      req_wstrb;
    logic [1:0]             byte_off;
    dcache_pkg::load_kind_t load_kind;
    dcache_pkg::word_t      merged;
    dcache_pkg::word_t      load_data;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .index          (index),
        .tag_rdata      (tag_rdata),
        .data_rdata     (data_rdata),
        .tag_we         (tag_we),
        .data_we        (data_we),
        .tag_wdata      (tag_wdata),
        .data_wdata     (data_wdata),
        .sel_word       (sel_word),
        .req_wdata      (req_wdata),
        .req_wstrb      (req_wstrb),
        .byte_off       (byte_off),
        .load_kind      (load_kind),
        .merged         (merged),
        .load_data      (load_data)
    );

    byte_lane_unit u_lane (
        .word_in   (sel_word),
        .wdata     (req_wdata),
        .wstrb     (req_wstrb),
        .byte_off  (byte_off),
        .load_kind (load_kind),
        .merged    (merged),
        .load_data (load_data)
    );

    // one tag and one data array per way
    for (genvar w = 0; w < dcache_pkg::way_num; w++) begin : g_way
        cache_array #(.entry_t(dcache_pkg::tag_entry_t)) u_tag (
            .clk   (clk),
            .rst_n (rst_n),
            .index (index),
            .we    (tag_we[w]),
            .wdata (tag_wdata),
            .rdata (tag_rdata[w])
        );

        cache_array #(.entry_t(dcache_pkg::line_t)) u_data (
            .clk   (clk),
            .rst_n (rst_n),
            .index (index),
            .we    (data_we[w]),
            .wdata (data_wdata),
            .rdata (data_rdata[w])
        );
    end

endmodule

//--- testbench/line_mem_model.sv
// line-wide memory model
module line_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_req_valid,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_req_ready,
    output logic                 mem_resp_valid,
    output dcache_pkg::line_t    mem_resp_data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int resp_delay = 2;   // cycles from transfer to response

    dcache_pkg::line_t    lines [dcache_pkg::addr_t];   // only lines written back
    dcache_pkg::mem_req_t held;
    logic                 accepted;
    logic                 pending;
    int                   wait_cnt;

    // untouched lines read as word address xor a fixed pattern
    function automatic dcache_pkg::line_t read_line(dcache_pkg::addr_t addr);
        dcache_pkg::line_t line;
        dcache_pkg::addr_t word_addr;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        for (int w = 0; w < dcache_pkg::line_words; w++) begin
            word_addr = (addr >> 2) + dcache_pkg::addr_t'(w);
            line[32*w +: 32] = word_addr ^ 32'h5a5a_0000;
        end
        return line;
    endfunction

    initial begin
        void'($urandom(68996));
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        pending        = 1'b0;
        wait_cnt       = 0;
        forever begin
            @(negedge clk);   // levels here hold until the next rising edge
            accepted = rst_n && mem_req_valid && mem_req_ready;
            if (accepted) begin
                held = mem_req;
            end
            @(posedge clk);
            #1;
            mem_resp_valid = 1'b0;
            if (!rst_n) begin
                pending       = 1'b0;
                mem_req_ready = 1'b0;
            end else begin
                if (accepted) begin
                    pending  = 1'b1;
                    wait_cnt = resp_delay - 1;
                end else if (pending) begin
                    wait_cnt--;
                end
                if (pending && wait_cnt == 0) begin
                    if (held.write) begin
                        lines[held.addr] = held.data;   // write just acks
                    end else begin
                        mem_resp_data = read_line(held.addr);
                    end
                    mem_resp_valid = 1'b1;
                    pending        = 1'b0;
                end
                // random stalls, about one cycle in four
                mem_req_ready = !pending && ($urandom_range(3, 0) != 0);
            end
        end
    end

endmodule

//--- testbench/dcache_tb.sv
// data cache testbench
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                   write;
        dcache_pkg::addr_t      addr;
        dcache_pkg::strb_t      strb;
        dcache_pkg::word_t      wdata;
        dcache_pkg::load_kind_t load_kind;
        dcache_pkg::word_t      expected_word;
    } op_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 req_valid;
    dcache_pkg::cpu_req_t req;
    logic                 req_ready;
    logic                 resp_valid;
    dcache_pkg::word_t    resp_rdata;
    logic                 mem_req_valid;
    dcache_pkg::mem_req_t mem_req;
    logic                 mem_req_ready;
    logic                 mem_resp_valid;
    dcache_pkg::line_t    mem_resp_data;

    op_t        ops [64];
    int         op_count;
    logic [7:0] shadow [dcache_pkg::addr_t];   // byte view of memory
    int         errors;
    int         checks;
    int         cycles;
    int         cycle_limit;
    int         cur_op;

    dcache_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    line_mem_model u_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles: op %0d never got a response", cycles, cur_op);
            $display("%0d checks, %0d errors", checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_word(input string what, input dcache_pkg::word_t actual,
                              input dcache_pkg::word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s returned %08h, expected %08h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic add_store(input dcache_pkg::addr_t addr, input dcache_pkg::strb_t strb,
                             input dcache_pkg::word_t wdata);
        ops[op_count] = {1'b1, addr, strb, wdata, dcache_pkg::lk_word, 32'h0};
        op_count++;
    endtask

    task automatic add_load(input dcache_pkg::addr_t addr, input dcache_pkg::load_kind_t kind);
        ops[op_count] = {1'b0, addr, 4'h0, 32'h0, kind, 32'h0};
        op_count++;
    endtask

    // memory that no store touched yet holds its initial fill
    function automatic logic [7:0] shadow_byte(input dcache_pkg::addr_t addr);
        dcache_pkg::word_t fill;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        fill = (addr >> 2) ^ 32'h5a5a_0000;
        return fill[8*addr[1:0] +: 8];
    endfunction

    function automatic dcache_pkg::word_t predict_load(input dcache_pkg::addr_t addr,
                                                       input dcache_pkg::load_kind_t kind);
        dcache_pkg::addr_t base;
        dcache_pkg::addr_t half_base;
        logic [7:0]        b;
        logic [15:0]       h;
        base      = {addr[31:2], 2'b00};
        half_base = {addr[31:1], 1'b0};
        b = shadow_byte(addr);
        h = {shadow_byte(half_base + 32'd1), shadow_byte(half_base)};   // little endian
        case (kind)
            dcache_pkg::lk_byte:   return {{24{b[7]}}, b};
            dcache_pkg::lk_byte_u: return {24'h0, b};
            dcache_pkg::lk_half:   return {{16{h[15]}}, h};
            dcache_pkg::lk_half_u: return {16'h0, h};
            default: begin
                return {shadow_byte(base + 32'd3), shadow_byte(base + 32'd2),
                        shadow_byte(base + 32'd1), shadow_byte(base)};
            end
        endcase
    endfunction

    task automatic apply_store(input op_t op);
        dcache_pkg::addr_t base;
        base = {op.addr[31:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            if (op.strb[i]) begin
                shadow[base + dcache_pkg::addr_t'(i)] = op.wdata[8*i +: 8];
            end
        end
    endtask

    // walk the table in order so each load sees all earlier stores
    task automatic fill_expected();
        for (int i = 0; i < op_count; i++) begin
            if (ops[i].write) begin
                apply_store(ops[i]);
            end else begin
                ops[i].expected_word = predict_load(ops[i].addr, ops[i].load_kind);
            end
        end
    endtask

    task automatic build_table();
        // cold miss, then a hit on the same line
        add_load(32'h0000_0100, dcache_pkg::lk_word);
        add_load(32'h0000_0104, dcache_pkg::lk_word);
        // partial store on a miss, then on a hit
        add_store(32'h0000_0204, 4'b0101, 32'hdead_beef);
        add_load(32'h0000_0204, dcache_pkg::lk_word);
        add_store(32'h0000_0204, 4'b1010, 32'h1122_3344);
        add_load(32'h0000_0204, dcache_pkg::lk_word);
        add_store(32'h0000_0108, 4'b1100, 32'hcafe_0000);
        add_load(32'h0000_0108, dcache_pkg::lk_word);
        // every byte has its top bit set
        add_store(32'h0000_0330, 4'b1111, 32'hf1e2_d3c4);
        for (int off = 0; off < 4; off++) begin
            add_load(32'h0000_0330 + dcache_pkg::addr_t'(off), dcache_pkg::lk_byte);
            add_load(32'h0000_0330 + dcache_pkg::addr_t'(off), dcache_pkg::lk_byte_u);
        end
        for (int off = 0; off < 4; off += 2) begin
            add_load(32'h0000_0330 + dcache_pkg::addr_t'(off), dcache_pkg::lk_half);
            add_load(32'h0000_0330 + dcache_pkg::addr_t'(off), dcache_pkg::lk_half_u);
        end
        add_store(32'h0000_0334, 4'b1111, 32'h7f80_017e);
        add_load(32'h0000_0335, dcache_pkg::lk_byte);
        add_load(32'h0000_0336, dcache_pkg::lk_half);
        // three tags in set 5 force a dirty eviction
        add_store(32'h0000_1050, 4'b1111, 32'haaaa_0001);
        add_store(32'h0000_2050, 4'b1111, 32'hbbbb_0002);
        add_store(32'h0000_3050, 4'b1111, 32'hcccc_0003);
        add_load(32'h0000_1050, dcache_pkg::lk_word);
        add_load(32'h0000_1054, dcache_pkg::lk_word);
        add_load(32'h0000_2050, dcache_pkg::lk_word);
        add_load(32'h0000_3050, dcache_pkg::lk_word);
    endtask

    task automatic run_op(input int idx, input op_t op);
        @(posedge clk);
        #1;
        req_valid     = 1'b1;
        req.write     = op.write;
        req.addr      = op.addr;
        req.strb      = op.strb;
        req.wdata     = op.wdata;
        req.load_kind = op.load_kind;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);   // transfer edge
        #1;
        req_valid = 1'b0;
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
        end
        if (!op.write) begin
            check_word($sformatf("op %0d load at %08h", idx, op.addr), resp_rdata,
                       op.expected_word);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        errors    = 0;
        checks    = 0;
        op_count  = 0;
        cur_op    = -1;
        build_table();
        fill_expected();
        cycle_limit = 40 * op_count + 100;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("req_ready after reset", req_ready, 1'b1);
        check_flag("resp_valid after reset", resp_valid, 1'b0);
        check_flag("mem_req_valid after reset", mem_req_valid, 1'b0);
        for (int i = 0; i < op_count; i++) begin
            cur_op = i;
            run_op(i, ops[i]);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/dcache_pkg.sv
hw/cache_array.sv
hw/byte_lane_unit.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/line_mem_model.sv
testbench/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module dcache_tb \
    -f flist.f -o dcache_sim > build.log 2>&1 \
    && ./obj_dir/dcache_sim > sim.log 2>&1 ; cat build.log sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
